//--- rtl/dmaPkg.sv
package dmaPkg;

    localparam int NUM_CHANNELS      = 4;
    localparam int MODE_AUTOINIT_BIT = 4;   // reload base on terminal count
    localparam int MODE_DEC_BIT      = 5;   // address counts down

    typedef logic [7:0]  byte_t;
    typedef logic [15:0] addr_t;
    typedef logic [15:0] count_t;
    typedef logic [1:0]  chan_t;

    // host register map where the byte pointer picks the low or high half
    typedef enum logic [3:0] {
        CH0_ADDR     = 4'd0,
        CH0_COUNT    = 4'd1,
        CH1_ADDR     = 4'd2,
        CH1_COUNT    = 4'd3,
        CH2_ADDR     = 4'd4,
        CH2_COUNT    = 4'd5,
        CH3_ADDR     = 4'd6,
        CH3_COUNT    = 4'd7,
        STATUS       = 4'd8,
        MODE         = 4'd11,
        CLEAR_PTR    = 4'd12,
        MASTER_CLEAR = 4'd13
    } regSel_t;

    typedef struct packed {
        logic     write;
        regSel_t  sel;
        byte_t    data;
    } hostReq_t;

    typedef struct packed {
        logic   en;
        logic   isCount;    // 1 = count register, 0 = address register
        chan_t  chan;
        logic   high;       // byte pointer at the time of the access
        byte_t  data;
    } regWrite_t;

    typedef struct packed {
        logic   valid;
        chan_t  chan;
        byte_t  data;
    } modeWrite_t;

    typedef struct packed {
        chan_t  chan;
        addr_t  addr;
        logic   tc;
    } stepResult_t;

    typedef struct packed {
        logic    en;
        chan_t   chan;
        addr_t   addr;
        count_t  count;
        logic    tc;
    } stepCommit_t;

endpackage

//--- rtl/hostDecoder.sv
`timescale 1ns/10ps

module hostDecoder import dmaPkg::*; (
    input  logic                          dif,
    input  logic                          reset,
    input  logic                          hostValid,
    input  hostReq_t                      hostReq,
    output logic                          hostReady,
    output logic                          rdValid,
    output byte_t                         rdData,
    output regWrite_t                     regWrite,
    output modeWrite_t                    modeWrite,
    output logic                          masterClear,
    input  addr_t  [NUM_CHANNELS-1:0]     currAddr,
    input  count_t [NUM_CHANNELS-1:0]     currCount,
    input  stepCommit_t                   stepCommit
);

    logic                    accept;
    logic                    bytePtr;       // 0 = low byte next
    logic [NUM_CHANNELS-1:0] statusBits;
    logic                    isChanReg;
    logic                    isStatus;
    logic                    isMode;
    logic                    isClearPtr;
    logic                    isMasterClear;
    chan_t                   selChan;
    byte_t                   addrByte;
    byte_t                   countByte;
    byte_t                   rdNext;

    // the commit cycle belongs to the step side
    assign hostReady = !stepCommit.en;
    assign accept    = hostValid && hostReady;
    assign selChan   = hostReq.sel[2:1];

    always_comb begin
        isChanReg     = 1'b0;
        isStatus      = 1'b0;
        isMode        = 1'b0;
        isClearPtr    = 1'b0;
        isMasterClear = 1'b0;
        case (hostReq.sel)
            CH0_ADDR, CH0_COUNT, CH1_ADDR, CH1_COUNT,
            CH2_ADDR, CH2_COUNT, CH3_ADDR, CH3_COUNT: isChanReg = 1'b1;
            STATUS:       isStatus      = 1'b1;
            MODE:         isMode        = 1'b1;
            CLEAR_PTR:    isClearPtr    = 1'b1;
            MASTER_CLEAR: isMasterClear = 1'b1;
            default:      ;                         // unmapped codes have no effect
        endcase
    end

    // decoded strobes toward the register file
    always_comb begin
        regWrite.en      = accept && hostReq.write && isChanReg;
        regWrite.isCount = hostReq.sel[0];
        regWrite.chan    = selChan;
        regWrite.high    = bytePtr;
        regWrite.data    = hostReq.data;

        modeWrite.valid  = accept && hostReq.write && isMode;
        modeWrite.chan   = hostReq.data[1:0];       // channel select lives in the data byte
        modeWrite.data   = hostReq.data;
    end

    assign masterClear = accept && hostReq.write && isMasterClear;

    always_ff @(posedge dif) begin
        if (reset || masterClear) begin
            bytePtr <= 1'b0;
        end else if (accept && hostReq.write && isClearPtr) begin
            bytePtr <= 1'b0;
        end else if (accept && isChanReg) begin
            bytePtr <= !bytePtr;                    // reads and writes both flip it
        end
    end

    // terminal count latches that a status read clears
    always_ff @(posedge dif) begin
        if (reset || masterClear) begin
            statusBits <= '0;
        end else begin
            if (accept && !hostReq.write && isStatus)
                statusBits <= '0;
            if (stepCommit.en && stepCommit.tc)
                statusBits[stepCommit.chan] <= 1'b1;
        end
    end

    assign addrByte  = bytePtr ? currAddr[selChan][15:8] : currAddr[selChan][7:0];
    assign countByte = bytePtr ? currCount[selChan][15:8] : currCount[selChan][7:0];

    always_comb begin
        rdNext = '0;
        if (isChanReg)
            rdNext = hostReq.sel[0] ? countByte : addrByte;
        else if (isStatus)
            rdNext = {{(8-NUM_CHANNELS){1'b0}}, statusBits};   // no request bits here
    end

    always_ff @(posedge dif) begin
        if (reset)
            rdValid <= 1'b0;
        else
            rdValid <= accept && !hostReq.write;
    end

    always_ff @(posedge dif) begin
        if (accept && !hostReq.write)
            rdData <= rdNext;
    end

endmodule

//--- rtl/channelRegs.sv
`timescale 1ns/10ps

module channelRegs import dmaPkg::*; (
    input  logic                          dif,
    input  logic                          reset,
    input  regWrite_t                     regWrite,
    input  modeWrite_t                    modeWrite,
    input  logic                          masterClear,
    input  stepCommit_t                   stepCommit,
    output addr_t  [NUM_CHANNELS-1:0]     currAddr,
    output count_t [NUM_CHANNELS-1:0]     currCount,
    output byte_t  [NUM_CHANNELS-1:0]     modeRegs
);

    addr_t  [NUM_CHANNELS-1:0] baseAddr;
    count_t [NUM_CHANNELS-1:0] baseCount;
    chan_t                     wrChan;
    chan_t                     cmChan;
    logic                      autoInit;

    // replace one half of a 16-bit register
    function automatic logic [15:0] setByte(
        input logic [15:0] word,
        input logic        high,
        input byte_t       data
    );
        logic [15:0] result;
        result = word;
        if (high)
            result[15:8] = data;
        else
            result[7:0] = data;
        return result;
    endfunction

    assign wrChan   = regWrite.chan;
    assign cmChan   = stepCommit.chan;
    assign autoInit = modeRegs[cmChan][MODE_AUTOINIT_BIT];

    always_ff @(posedge dif) begin
        if (reset || masterClear) begin
            baseAddr  <= '0;
            baseCount <= '0;
            currAddr  <= '0;
            currCount <= '0;
        end else begin
            // a host write loads base and current together
            if (regWrite.en) begin
                if (regWrite.isCount) begin
                    baseCount[wrChan] <= setByte(baseCount[wrChan], regWrite.high,
                                                 regWrite.data);
                    currCount[wrChan] <= setByte(currCount[wrChan], regWrite.high,
                                                 regWrite.data);
                end else begin
                    baseAddr[wrChan] <= setByte(baseAddr[wrChan], regWrite.high,
                                                regWrite.data);
                    currAddr[wrChan] <= setByte(currAddr[wrChan], regWrite.high,
                                                regWrite.data);
                end
            end

            // step commit last so it wins over a host write
            if (stepCommit.en) begin
                if (!stepCommit.tc) begin
                    currAddr[cmChan]  <= stepCommit.addr;
                    currCount[cmChan] <= stepCommit.count;
                end else if (autoInit) begin
                    currAddr[cmChan]  <= baseAddr[cmChan];    // autoinit reload
                    currCount[cmChan] <= baseCount[cmChan];
                end else begin
                    currAddr[cmChan]  <= '0;
                    currCount[cmChan] <= '0;
                end
            end
        end
    end

    always_ff @(posedge dif) begin
        if (reset || masterClear) begin
            modeRegs <= '0;
        end else if (modeWrite.valid) begin
            modeRegs[modeWrite.chan] <= modeWrite.data;
        end
    end

endmodule

//--- rtl/stepEngine.sv
`timescale 1ns/10ps

module stepEngine import dmaPkg::*; (
    input  logic                          dif,
    input  logic                          reset,
    input  logic                          stepValid,
    input  chan_t                         stepChan,
    output logic                          stepReady,
    output logic                          stepOutValid,
    output stepResult_t                   stepOut,
    input  logic                          stepOutReady,
    input  addr_t  [NUM_CHANNELS-1:0]     currAddr,
    input  count_t [NUM_CHANNELS-1:0]     currCount,
    input  byte_t  [NUM_CHANNELS-1:0]     modeRegs,
    output stepCommit_t                   stepCommit
);

    typedef enum logic [1:0] {
        IDLE,
        CALC,
        HOLD
    } stepState_t;

    stepState_t state;
    chan_t      chanReg;
    addr_t      usedAddr;
    addr_t      nextAddr;
    count_t     nextCount;
    logic       tcFlag;
    logic       done;

    assign stepReady    = (state == IDLE);
    assign stepOutValid = (state == HOLD);
    assign done         = stepOutValid && stepOutReady;

    always_ff @(posedge dif) begin
        if (reset) begin
            state <= IDLE;
        end else begin
            case (state)
                IDLE:    if (stepValid) state <= CALC;
                CALC:    state <= HOLD;
                HOLD:    if (stepOutReady) state <= IDLE;
                default: state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge dif) begin
        if (stepValid && stepReady)
            chanReg <= stepChan;
        if (state == CALC) begin
            usedAddr <= currAddr[chanReg];
            if (modeRegs[chanReg][MODE_DEC_BIT])
                nextAddr <= currAddr[chanReg] - addr_t'(1);
            else
                nextAddr <= currAddr[chanReg] + addr_t'(1);
            tcFlag    <= (currCount[chanReg] == '0);
            nextCount <= (currCount[chanReg] == '0) ? '0 : currCount[chanReg] - count_t'(1);
        end
    end

    assign stepOut = '{chan: chanReg, addr: usedAddr, tc: tcFlag};

    // commit goes out in the handshake cycle only
    assign stepCommit = '{en: done, chan: chanReg, addr: nextAddr,
                          count: nextCount, tc: tcFlag};

endmodule

//--- rtl/dmaDatapath.sv
`timescale 1ns/10ps

module dmaDatapath import dmaPkg::*; (
    input  logic        dif,
    input  logic        reset,
    input  logic        hostValid,
    input  hostReq_t    hostReq,
    output logic        hostReady,
    output logic        rdValid,
    output byte_t       rdData,
    input  logic        stepValid,
    input  chan_t       stepChan,
    output logic        stepReady,
    output logic        stepOutValid,
    output stepResult_t stepOut,
    input  logic        stepOutReady
);

    regWrite_t                 regWrite;
    modeWrite_t                modeWrite;
    logic                      masterClear;
    stepCommit_t               stepCommit;
    addr_t  [NUM_CHANNELS-1:0] currAddr;
    count_t [NUM_CHANNELS-1:0] currCount;
    byte_t  [NUM_CHANNELS-1:0] modeRegs;

    hostDecoder hostDec (
        .dif         (dif),
        .reset       (reset),
        .hostValid   (hostValid),
        .hostReq     (hostReq),
        .hostReady   (hostReady),
        .rdValid     (rdValid),
        .rdData      (rdData),
        .regWrite    (regWrite),
        .modeWrite   (modeWrite),
        .masterClear (masterClear),
        .currAddr    (currAddr),
        .currCount   (currCount),
        .stepCommit  (stepCommit)
    );

    channelRegs chanRegs (
        .dif         (dif),
        .reset       (reset),
        .regWrite    (regWrite),
        .modeWrite   (modeWrite),
        .masterClear (masterClear),
        .stepCommit  (stepCommit),
        .currAddr    (currAddr),
        .currCount   (currCount),
        .modeRegs    (modeRegs)
    );

    stepEngine stepEng (
        .dif          (dif),
        .reset        (reset),
        .stepValid    (stepValid),
        .stepChan     (stepChan),
        .stepReady    (stepReady),
        .stepOutValid (stepOutValid),
        .stepOut      (stepOut),
        .stepOutReady (stepOutReady),
        .currAddr     (currAddr),
        .currCount    (currCount),
        .modeRegs     (modeRegs),
        .stepCommit   (stepCommit)
    );

endmodule

//--- tb/dmaTbTasks.svh
`ifndef DMA_TB_TASKS_SVH
`define DMA_TB_TASKS_SVH

// Galois LFSR stepped once for every bit taken
function automatic logic [31:0] randBits(input int n);
    logic [31:0] value;
    value = '0;
    for (int i = 0; i < n; i++) begin
        value = {value[30:0], lfsr[0]};
        lfsr  = lfsr[0] ? ((lfsr >> 1) ^ 32'h80200003) : (lfsr >> 1);
    end
    return value;
endfunction

function automatic void clearModel();
    for (int c = 0; c < NUM_CHANNELS; c++) begin
        mAddrBase[c] = '0;
        mAddrCur[c]  = '0;
        mCntBase[c]  = '0;
        mCntCur[c]   = '0;
        mMode[c]     = '0;
    end
    mPtr    = 1'b0;
    mStatus = '0;
endfunction

// host side of the model that also sets the byte a read should return
function automatic void modelAccess(input logic w, input logic [3:0] sel, input byte_t d);
    chan_t c;
    int    lo;
    c  = sel[2:1];
    lo = mPtr ? 8 : 0;
    if (sel < 4'd8) begin
        if (w && sel[0]) begin
            mCntBase[c][lo +: 8] = d;
            mCntCur[c][lo +: 8]  = d;
        end else if (w) begin
            mAddrBase[c][lo +: 8] = d;
            mAddrCur[c][lo +: 8]  = d;
        end else begin
            expRd = sel[0] ? mCntCur[c][lo +: 8] : mAddrCur[c][lo +: 8];
        end
        mPtr = !mPtr;
    end else if (!w && sel == STATUS) begin
        expRd   = {4'b0000, mStatus};
        mStatus = '0;                           // read clears after returning
    end else if (w && sel == MODE) begin
        mMode[d[1:0]] = d;
    end else if (w && sel == CLEAR_PTR) begin
        mPtr = 1'b0;
    end else if (w && sel == MASTER_CLEAR) begin
        clearModel();
    end else if (!w) begin
        expRd = '0;
    end
endfunction

function automatic void commitModel();
    chan_t c;
    c = expStep.chan;
    if (expStep.tc) begin
        mStatus[c]  = 1'b1;
        mAddrCur[c] = mMode[c][MODE_AUTOINIT_BIT] ? mAddrBase[c] : 16'd0;
        mCntCur[c]  = mMode[c][MODE_AUTOINIT_BIT] ? mCntBase[c] : 16'd0;
    end else begin
        mAddrCur[c] = mMode[c][MODE_DEC_BIT] ? mAddrCur[c] - 16'd1 : mAddrCur[c] + 16'd1;
        mCntCur[c]  = mCntCur[c] - 16'd1;
    end
endfunction

task automatic hostAccess(input logic w, input logic [3:0] sel, input byte_t d);
    @(posedge dif);
    hostValid <= 1'b1;
    hostReq   <= '{write: w, sel: regSel_t'(sel), data: d};
    @(negedge dif);
    while (!hostReady)
        @(negedge dif);
    modelAccess(w, sel, d);                     // taken on the next rising edge
    @(posedge dif);
    hostValid <= 1'b0;
endtask

task automatic writeReg(input logic [3:0] sel, input byte_t d);
    hostAccess(1'b1, sel, d);
endtask

task automatic readReg(input logic [3:0] sel);
    hostAccess(1'b0, sel, 8'h00);
endtask

// request a step and wait until its result is presented
task automatic startStep(input chan_t c);
    @(posedge dif);
    stepValid <= 1'b1;
    stepChan  <= c;
    @(negedge dif);
    while (!stepReady)
        @(negedge dif);
    expStep = '{chan: c, addr: mAddrCur[c], tc: (mCntCur[c] == 16'd0)};
    @(posedge dif);
    stepValid <= 1'b0;
    @(negedge dif);
    while (!stepOutValid)
        @(negedge dif);
endtask

task automatic finishStep();
    @(posedge dif);
    stepOutReady <= 1'b1;
    @(posedge dif);                             // handshake and commit on this edge
    stepOutReady <= 1'b0;
    commitModel();
endtask

task automatic doStep(input chan_t c);
    startStep(c);
    finishStep();
endtask

`endif

//--- tb/dmaTb.sv
`timescale 1ns/10ps

module dmaTb import dmaPkg::*; ();

    localparam int CYCLE_LIMIT = 4000;          // well above the length of all six tests

    logic        dif = 1'b0;
    logic        reset;
    logic        hostValid;
    hostReq_t    hostReq;
    logic        hostReady;
    logic        rdValid;
    byte_t       rdData;
    logic        stepValid;
    chan_t       stepChan;
    logic        stepReady;
    logic        stepOutValid;
    stepResult_t stepOut;
    logic        stepOutReady;

    // reference model
    logic [15:0] mAddrBase [NUM_CHANNELS];
    logic [15:0] mAddrCur  [NUM_CHANNELS];
    logic [15:0] mCntBase  [NUM_CHANNELS];
    logic [15:0] mCntCur   [NUM_CHANNELS];
    byte_t       mMode     [NUM_CHANNELS];
    logic        mPtr;
    logic [3:0]  mStatus;
    byte_t       expRd;
    stepResult_t expStep;

    logic [31:0] lfsr = 32'hf68a141c;
    int          errCount = 0;
    int          errMark = 0;
    int          testsRun = 0;
    int          testsFailed = 0;
    int          cycles = 0;

    `include "dmaTbTasks.svh"

    dmaDatapath dut_i (
        .dif          (dif),
        .reset        (reset),
        .hostValid    (hostValid),
        .hostReq      (hostReq),
        .hostReady    (hostReady),
        .rdValid      (rdValid),
        .rdData       (rdData),
        .stepValid    (stepValid),
        .stepChan     (stepChan),
        .stepReady    (stepReady),
        .stepOutValid (stepOutValid),
        .stepOut      (stepOut),
        .stepOutReady (stepOutReady)
    );

    initial begin
        forever #4 dif = ~dif;
    end

    always @(posedge dif) begin
        cycles <= cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            $display("timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("*** TEST FAILED ***");
            $finish;
        end
    end

    assert property (@(posedge dif) disable iff (reset)
            rdValid == $past(hostValid && hostReady && !hostReq.write))
        else begin
            errCount++;
            $display("%0t: rdValid was not a single pulse one cycle after a read", $time);
        end

    assert property (@(posedge dif) disable iff (reset) rdValid |-> rdData == expRd)
        else begin
            errCount++;
            $display("ERROR %0t rdData got %h expected %h", $time, $sampled(rdData),
                     $sampled(expRd));
        end

    // the host side is held off only while a step commits
    assert property (@(posedge dif) disable iff (reset)
            hostReady == !(stepOutValid && stepOutReady))
        else begin
            errCount++;
            $display("ERROR %0t hostReady got %b expected %b", $time, $sampled(hostReady),
                     !($sampled(stepOutValid) && $sampled(stepOutReady)));
        end

    assert property (@(posedge dif) disable iff (reset) stepOutValid |-> stepOut == expStep)
        else begin
            errCount++;
            $display("ERROR %0t stepOut got %h expected %h", $time, $sampled(stepOut),
                     $sampled(expStep));
        end

    assert property (@(posedge dif) disable iff (reset)
            stepOutValid && !stepOutReady |=> stepOutValid && $stable(stepOut))
        else begin
            errCount++;
            $display("%0t: stepOut changed or dropped while stepOutReady was low", $time);
        end

    assert property (@(posedge dif) disable iff (reset) stepOutValid |-> !stepReady)
        else begin
            errCount++;
            $display("%0t: stepReady was high while a step result was waiting", $time);
        end

    task automatic endTest(input string name);
        repeat (2) @(posedge dif);              // let the last read be checked
        testsRun++;
        if (errCount == errMark) begin
            $display("test %0d %s: ok", testsRun, name);
        end else begin
            testsFailed++;
            $display("test %0d %s: %0d errors", testsRun, name, errCount - errMark);
        end
        errMark = errCount;
    endtask

    initial begin
        reset        <= 1'b1;
        hostValid    <= 1'b0;
        hostReq      <= '0;
        stepValid    <= 1'b0;
        stepChan     <= '0;
        stepOutReady <= 1'b0;
        clearModel();
        repeat (8) @(posedge dif);
        reset <= 1'b0;

        @(negedge dif);
        assert (hostReady && stepReady && !rdValid && !stepOutValid)
            else begin
                errCount++;
                $display("ERROR %0t hostReady,stepReady,rdValid,stepOutValid got %b expected 1100",
                         $time, {hostReady, stepReady, rdValid, stepOutValid});
            end
        for (int r = 0; r < 8; r++) begin
            readReg(4'(r));
            readReg(4'(r));
        end
        readReg(STATUS);
        endTest("reset values");

        for (int r = 0; r < 8; r++) begin
            writeReg(4'(r), byte_t'(randBits(8)));
            writeReg(4'(r), byte_t'(randBits(8)));
            readReg(4'(r));
            readReg(4'(r));
        end
        writeReg(CH1_COUNT, byte_t'(randBits(8)));  // pointer now on the high byte
        writeReg(CLEAR_PTR, 8'h00);
        writeReg(CH1_COUNT, byte_t'(randBits(8)));
        readReg(CH1_COUNT);
        readReg(CH1_COUNT);
        endTest("byte writes and pointer");

        writeReg(MODE, 8'h00);                  // channel 0 counts up
        writeReg(MODE, 8'h21);                  // channel 1 counts down
        repeat (3) begin
            doStep(2'd0);
            doStep(2'd1);
        end
        for (int r = 0; r < 4; r++) begin
            readReg(4'(r));
            readReg(4'(r));
        end
        endTest("step address and count");

        writeReg(CLEAR_PTR, 8'h00);
        writeReg(MODE, 8'h12);                  // channel 2 autoinit
        writeReg(MODE, 8'h23);                  // channel 3 down, clears on tc
        writeReg(CH2_COUNT, 8'h02);
        writeReg(CH2_COUNT, 8'h00);
        writeReg(CH3_COUNT, 8'h01);
        writeReg(CH3_COUNT, 8'h00);
        repeat (3) doStep(2'd2);
        repeat (2) doStep(2'd3);
        readReg(STATUS);
        readReg(STATUS);
        for (int r = 4; r < 8; r++) begin
            readReg(4'(r));
            readReg(4'(r));
        end
        endTest("terminal count and reload");

        for (int s = 0; s < 3; s++) begin
            startStep(chan_t'(s));
            repeat (2) begin
                repeat (randBits(3) + 1) @(posedge dif);
                readReg(4'(2 * s));
                readReg(4'(2 * s));
                readReg(4'(2 * s + 1));
                readReg(4'(2 * s + 1));
            end
            finishStep();
        end
        endTest("step back-pressure");

        doStep(2'd3);                           // count is zero so this sets a status bit
        if (!mPtr)
            readReg(CH0_ADDR);                  // leave the pointer on the high byte
        writeReg(MASTER_CLEAR, 8'h00);
        writeReg(CH1_ADDR, 8'h10);
        writeReg(CH1_ADDR, 8'h00);
        writeReg(CH1_COUNT, 8'h01);
        writeReg(CH1_COUNT, 8'h00);
        doStep(2'd1);                           // cleared mode counts up
        for (int r = 0; r < 8; r++) begin
            readReg(4'(r));
            readReg(4'(r));
        end
        readReg(STATUS);
        readReg(4'd9);                          // unmapped code
        endTest("master clear");

        $display("%0d tests run, %0d failed, %0d errors", testsRun, testsFailed, errCount);
        if (errCount == 0)
            $display("*** TEST PASSED ***");
        else
            $display("*** TEST FAILED ***");
        $finish;
    end

endmodule

//--- dmaDatapath.f
+incdir+tb
rtl/dmaPkg.sv
rtl/hostDecoder.sv
rtl/channelRegs.sv
rtl/stepEngine.sv
rtl/dmaDatapath.sv
tb/dmaTb.sv

//--- run.sh
#!/bin/sh
# build and run the DMA datapath testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert --top-module dmaTb -f dmaDatapath.f > build.log 2>&1 &&
    ./obj_dir/VdmaTb > sim.log 2>&1 ||
    { echo "build or simulation did not complete, see build.log and sim.log"; exit 1; }
grep -qF '*** TEST PASSED ***' sim.log && echo "simulation passed" ||
    { echo "simulation failed, see sim.log"; exit 1; }
